// File: compile.f
+incdir+.
dcache_pkg.sv
dcache_lookup_if.sv
dcache_decode.sv
dcache_execute.sv
dcache_result.sv
dcache_top.sv
dcache_assertions.sv
dcache_checker.sv
tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_lookup_if.sv
      - dcache_decode.sv
      - dcache_execute.sv
      - dcache_result.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dcache_assertions.sv
      - dcache_checker.sv
      - tb_dcache.sv

// File: tb_dcache.sv
/* testbench for dcache_top; the memory model holds 256 words, so every
   table address stays below 0x400 */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 19;

    typedef enum logic [2:0] {OP_LW, OP_SW, OP_LL, OP_SC, OP_HALT} op_e;

    // exp only matters for SC since loads are checked against the shadow memory
    typedef struct packed {
        op_e   op;
        word_t addr;
        word_t data;
        word_t exp;
    } stim_t;

    logic  CLK, nRST;
    logic  dmemren, dmemwen, datomic, halt;
    word_t dmemaddr, dmemstore, dmemload, sc_expect;
    logic  dhit, flushed;
    logic  mem_req, mem_we, mem_credit, mem_rvalid;
    word_t mem_addr, mem_wdata, mem_rdata;
    int    tests, errors;
    word_t mem [256];
    stim_t stim [NUM_TESTS];

    dcache_top dut_i (.*);

    dcache_checker checker_i (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic apply_entry(input stim_t s);
        @(posedge CLK);
        #1;
        dmemren   = (s.op == OP_LW) || (s.op == OP_LL);
        dmemwen   = (s.op == OP_SW) || (s.op == OP_SC);
        datomic   = (s.op == OP_LL) || (s.op == OP_SC);
        halt      = (s.op == OP_HALT);
        dmemaddr  = s.addr;
        dmemstore = s.data;
        sc_expect = s.exp;
        if (s.op == OP_HALT) begin
            do @(negedge CLK); while (!flushed);
        end else begin
            do @(negedge CLK); while (!dhit);
        end
    endtask

    // memory model returning credits and read data 1 to 3 cycles after a request
    initial begin : memory_model
        int    cyc;
        int    last_due;
        int    grants;
        int    stall;
        int    due_q [$];
        logic  rd_q [$];
        word_t rdata_q [$];
        void'($urandom(42173));
        for (int n = 0; n < 256; n++)
            mem[n] = (n * 4) ^ 32'hA5A50000;
        mem_credit = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        cyc        = 0;
        last_due   = 0;
        grants     = `DCACHE_MEM_CREDITS;
        @(posedge nRST);
        forever begin
            @(posedge CLK);
            #1;
            cyc++;
            mem_credit = 1'b0;
            mem_rvalid = 1'b0;
            mem_rdata  = '0;
            if (grants > 0) begin
                mem_credit = 1'b1;  // initial grant of one per cycle
                grants--;
            end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
                void'(due_q.pop_front());
                mem_credit = 1'b1;
                mem_rvalid = rd_q.pop_front();
                mem_rdata  = rdata_q.pop_front();
            end
            @(negedge CLK);
            if (mem_req) begin
                // responses stay in order with at most one per cycle
                stall    = 1 + ($urandom % 3);
                last_due = (cyc + stall > last_due) ? cyc + stall : last_due + 1;
                due_q.push_back(last_due);
                rd_q.push_back(!mem_we);
                rdata_q.push_back(mem[mem_addr[9:2]]);
                if (mem_we)
                    mem[mem_addr[9:2]] = mem_wdata;
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (NUM_TESTS * 40 + 200));
        $display("timeout: the cache stopped answering after %0d tests", tests);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main
        nRST      = 1'b0;
        dmemren   = 1'b0;
        dmemwen   = 1'b0;
        datomic   = 1'b0;
        halt      = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        sc_expect = '0;
        stim = '{
            '{OP_LW,   32'h010, 32'h0,        32'h0},  // read miss
            '{OP_LW,   32'h010, 32'h0,        32'h0},  // read hit
            '{OP_SW,   32'h020, 32'h11112222, 32'h0},
            '{OP_LW,   32'h020, 32'h0,        32'h0},
            '{OP_LW,   32'h024, 32'h0,        32'h0},  // other word of block
            '{OP_SW,   32'h008, 32'hDEADBEEF, 32'h0},  // set 1 way 0
            '{OP_SW,   32'h04C, 32'h0BADF00D, 32'h0},  // set 1 way 1
            '{OP_LW,   32'h088, 32'h0,        32'h0},  // evicts dirty 0x008
            '{OP_LW,   32'h008, 32'h0,        32'h0},  // evicts dirty 0x04C
            '{OP_LW,   32'h04C, 32'h0,        32'h0},
            '{OP_LL,   32'h030, 32'h0,        32'h0},
            '{OP_SC,   32'h030, 32'h5C5C0001, 32'h1},
            '{OP_LW,   32'h030, 32'h0,        32'h0},
            '{OP_LL,   32'h0F0, 32'h0,        32'h0},
            '{OP_SW,   32'h0F0, 32'h77770000, 32'h0},  // breaks the link
            '{OP_SC,   32'h0F0, 32'h99990000, 32'h0},
            '{OP_LW,   32'h0F0, 32'h0,        32'h0},
            '{OP_SW,   32'h3F8, 32'h12345678, 32'h0},
            '{OP_HALT, 32'h0,   32'h0,        32'h0}
        };
        repeat (4) @(posedge CLK);
        #1 nRST = 1'b1;
        foreach (stim[i])
            apply_entry(stim[i]);
        @(posedge CLK);
        #1;
        dmemaddr = '0;
        repeat (2) @(negedge CLK);
        $display("tests %0d of %0d, check errors %0d, assertion failures %0d",
                 tests, NUM_TESTS, errors, dut_i.assertions_i.fail_count);
        if (tests != NUM_TESTS)
            $display("not every test in the table completed");
        if (errors == 0 && dut_i.assertions_i.fail_count == 0 && tests == NUM_TESTS)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: dcache_checker.sv
/* scoreboard on the dcache ports, sampled at the falling clock edge;
   shadow and memory image cover the first 256 words only */
`timescale 1ns/1ps

module dcache_checker (
    input  logic                CLK,
    input  logic                dmemren,
    input  logic                dmemwen,
    input  logic                datomic,
    input  dcache_pkg::word_t   dmemaddr,
    input  dcache_pkg::word_t   dmemstore,
    input  logic                dhit,
    input  dcache_pkg::word_t   dmemload,
    input  logic                flushed,
    input  logic                mem_req,
    input  logic                mem_we,
    input  dcache_pkg::word_t   mem_addr,
    input  dcache_pkg::word_t   mem_wdata,
    input  dcache_pkg::word_t   sc_expect,  // SC outcome from the stimulus table
    output int                  tests,
    output int                  errors
);
    import dcache_pkg::*;

    word_t shadow [256];  // memory as the datapath should see it
    word_t image  [256];  // writes that reached the memory port
    logic  stored [256];
    logic  flush_seen;

    initial begin
        for (int n = 0; n < 256; n++) begin
            shadow[n] = (n * 4) ^ 32'hA5A50000;
            image[n]  = shadow[n];
            stored[n] = 1'b0;
        end
        tests      = 0;
        errors     = 0;
        flush_seen = 1'b0;
    end

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    always @(negedge CLK) begin
        logic [7:0] w;
        int         err_before;
        string      op;
        err_before = errors;
        if (mem_req && mem_we)
            image[mem_addr[9:2]] = mem_wdata;
        if (dhit) begin
            w = dmemaddr[9:2];
            tests++;
            if (dmemwen && datomic) begin
                op = "SC";
                check_word("SC result", dmemload, sc_expect);
                if (sc_expect == 32'd1) begin
                    shadow[w] = dmemstore;
                    stored[w] = 1'b1;
                end
            end else if (dmemwen) begin
                op        = "store";
                shadow[w] = dmemstore;
                stored[w] = 1'b1;
            end else begin
                op = datomic ? "LL" : "load";
                check_word($sformatf("%s data at 0x%03h", op, dmemaddr), dmemload, shadow[w]);
            end
            $display("test %0d %s: %s 0x%03h", tests,
                     (errors == err_before) ? "ok" : "bad", op, dmemaddr);
        end
        // whole memory compared once the flush is over
        if (flushed && !flush_seen) begin
            flush_seen = 1'b1;
            tests++;
            for (int n = 0; n < 256; n++)
                if (stored[n])
                    check_word($sformatf("memory word 0x%03h", n * 4), image[n], shadow[n]);
            $display("test %0d %s: flush", tests, (errors == err_before) ? "ok" : "bad");
        end
    end

endmodule

// File: dcache_assertions.sv
/* protocol assertions bound into dcache_top; the credit count is rebuilt
   from the port traffic, so it assumes credits start at zero after reset */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_assertions (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                dmemren,
    input  logic                dmemwen,
    input  dcache_pkg::word_t   dmemaddr,
    input  logic                dhit,
    input  logic                flushed,
    input  logic                mem_req,
    input  logic                mem_credit
);

    int unsigned fail_count = 0;
    logic [2:0]  credit_cnt;  // credits held as seen from outside

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            credit_cnt <= '0;
        else
            credit_cnt <= credit_cnt + 3'(mem_credit) - 3'(mem_req);
    end

    a_req_needs_credit: assert property (@(posedge CLK) disable iff (!nRST)
        mem_req |-> credit_cnt != '0)
        else begin
            $error("mem_req raised with no credit held");
            fail_count++;
        end

    a_credit_bound: assert property (@(posedge CLK) disable iff (!nRST)
        credit_cnt <= `DCACHE_MEM_CREDITS)
        else begin
            $error("credit count above the memory limit");
            fail_count++;
        end

    // outputs quiet right after reset
    a_quiet_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |-> !dhit && !flushed && !mem_req)
        else begin
            $error("dhit, flushed or mem_req high right after reset");
            fail_count++;
        end

    a_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
        (dmemren || dmemwen) && !dhit |=> $stable(dmemaddr))
        else begin
            $error("dmemaddr changed while waiting for dhit");
            fail_count++;
        end

endmodule

bind dcache_top dcache_assertions assertions_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .dmemren    (dmemren),
    .dmemwen    (dmemwen),
    .dmemaddr   (dmemaddr),
    .dhit       (dhit),
    .flushed    (flushed),
    .mem_req    (mem_req),
    .mem_credit (mem_credit)
);

// File: dcache_top.sv
/* 2-way write-back data cache with credit-based memory port; requests held
   until dhit, word accesses only */
`timescale 1ns/1ps

module dcache_top (
    input  logic                CLK,
    input  logic                nRST,
    // datapath side
    input  logic                dmemren,
    input  logic                dmemwen,
    input  logic                datomic,
    input  dcache_pkg::word_t   dmemaddr,
    input  dcache_pkg::word_t   dmemstore,
    input  logic                halt,
    output logic                dhit,
    output dcache_pkg::word_t   dmemload,
    output logic                flushed,
    // memory side
    output logic                mem_req,
    output logic                mem_we,
    output dcache_pkg::word_t   mem_addr,
    output dcache_pkg::word_t   mem_wdata,
    input  logic                mem_credit,
    input  logic                mem_rvalid,
    input  dcache_pkg::word_t   mem_rdata
);

    logic sc_fail;

    dcache_lookup_if lk_if (.CLK(CLK));

    dcache_decode decode_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .dmemren  (dmemren),
        .dmemwen  (dmemwen),
        .dmemaddr (dmemaddr),
        .lk       (lk_if.lookup)
    );

    dcache_execute execute_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmemren    (dmemren),
        .dmemwen    (dmemwen),
        .datomic    (datomic),
        .halt       (halt),
        .dmemaddr   (dmemaddr),
        .mem_credit (mem_credit),
        .mem_rvalid (mem_rvalid),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .flushed    (flushed),
        .sc_fail    (sc_fail),
        .ct         (lk_if.ctrl)
    );

    dcache_result result_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmemren    (dmemren),
        .dmemwen    (dmemwen),
        .datomic    (datomic),
        .dmemaddr   (dmemaddr),
        .dmemstore  (dmemstore),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .dhit       (dhit),
        .dmemload   (dmemload),
        .mem_wdata  (mem_wdata),
        .sc_fail    (sc_fail),
        .dt         (lk_if.data)
    );

endmodule

// File: dcache_result.sv
/* data array, load mux and LL/SC link register; link compares word
   addresses, an SC of any outcome drops the link */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_result (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                dmemren,
    input  logic                dmemwen,
    input  logic                datomic,
    input  dcache_pkg::word_t   dmemaddr,
    input  dcache_pkg::word_t   dmemstore,
    input  logic                mem_rvalid,
    input  dcache_pkg::word_t   mem_rdata,
    output logic                dhit,
    output dcache_pkg::word_t   dmemload,
    output dcache_pkg::word_t   mem_wdata,
    output logic                sc_fail,
    dcache_lookup_if.data       dt
);
    import dcache_pkg::*;

    word_t   data_q [`DCACHE_SETS][`DCACHE_WAYS][`DCACHE_WORDS_PER_BLOCK];
    word_t   link_addr;
    logic    link_valid;
    logic    link_match;
    idx_t    req_idx;
    blkoff_t req_off;

    assign req_idx = dmemaddr[5:3];
    assign req_off = dmemaddr[2];

    assign dhit       = dt.hit & (dt.state == IDLE);
    assign link_match = (link_addr[31:2] == dmemaddr[31:2]);
    assign sc_fail    = dmemwen & datomic & ~(link_valid & link_match);

    always_comb begin
        if (dmemwen & datomic)
            dmemload = {31'b0, ~sc_fail};  // SC outcome
        else
            dmemload = data_q[req_idx][dt.hit_way][req_off];
    end

    // word going out for write-back or flush
    always_comb begin
        case (dt.state)
            WB0, WB1: mem_wdata = data_q[req_idx][dt.victim_way][blkoff_t'(dt.state == WB1)];
            FL0, FL1: mem_wdata = data_q[dt.scan_idx][dt.scan_way][blkoff_t'(dt.state == FL1)];
            default:  mem_wdata = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (mem_rvalid)
            data_q[req_idx][dt.victim_way][dt.rf_word] <= mem_rdata;  // refill
        else if (dhit && dmemwen && !sc_fail)
            data_q[req_idx][dt.hit_way][req_off] <= dmemstore;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            link_addr  <= '0;
            link_valid <= 1'b0;
        end else if (dhit) begin
            if (dmemren && datomic) begin
                link_addr  <= dmemaddr;
                link_valid <= 1'b1;
            end else if (dmemwen && (datomic || link_match)) begin
                link_valid <= 1'b0;
            end
        end
    end

endmodule

// File: dcache_execute.sv
/* miss, write-back and flush controller; a request state only issues while
   a credit is held, memory must never return more than DCACHE_MEM_CREDITS */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_execute (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                dmemren,
    input  logic                dmemwen,
    input  logic                datomic,
    input  logic                halt,
    input  dcache_pkg::word_t   dmemaddr,
    input  logic                mem_credit,
    input  logic                mem_rvalid,
    output logic                mem_req,
    output logic                mem_we,
    output dcache_pkg::word_t   mem_addr,
    output logic                flushed,
    input  logic                sc_fail,
    dcache_lookup_if.ctrl       ct
);
    import dcache_pkg::*;

    dcache_state_e state, next_state;
    credit_t       credits;
    blkoff_t       rf_word;
    idx_t          scan_idx;
    way_t          scan_way;
    logic          credit_ok;
    logic          scan_step;
    logic          scan_last;
    logic          sc_blocked;
    tag_t          req_tag;
    idx_t          req_idx;

    assign req_tag    = dmemaddr[31:6];
    assign req_idx    = dmemaddr[5:3];
    assign credit_ok  = (credits != '0);
    assign sc_blocked = datomic & sc_fail;
    assign scan_last  = (scan_idx == idx_t'(`DCACHE_SETS - 1)) &&
                        (scan_way == way_t'(`DCACHE_WAYS - 1));

    always_comb begin
        next_state     = state;
        mem_req        = 1'b0;
        mem_we         = 1'b0;
        mem_addr       = '0;
        ct.set_dirty   = 1'b0;
        ct.touch_lru   = 1'b0;
        ct.fill_valid  = 1'b0;
        ct.clean_frame = 1'b0;
        scan_step      = 1'b0;
        case (state)
            IDLE: begin
                if (halt) begin
                    next_state = FLSCAN;
                end else if (ct.hit) begin
                    ct.touch_lru = dmemren | ~sc_blocked;
                    ct.set_dirty = dmemwen & ~sc_blocked;
                end else if (dmemren | dmemwen) begin
                    next_state = (ct.victim_valid & ct.victim_dirty) ? WB0 : RF0;
                end
            end
            WB0, WB1: begin
                mem_req  = credit_ok;
                mem_we   = 1'b1;
                mem_addr = {ct.victim_tag, req_idx, blkoff_t'(state == WB1), 2'b00};
                if (credit_ok)
                    next_state = (state == WB0) ? WB1 : RF0;
            end
            RF0, RF1: begin
                mem_req  = credit_ok;
                mem_addr = {req_tag, req_idx, blkoff_t'(state == RF1), 2'b00};
                if (credit_ok)
                    next_state = (state == RF0) ? RF1 : RFWAIT;
            end
            RFWAIT: begin
                // last word arrives, tag goes valid on the same edge
                if (mem_rvalid && rf_word == blkoff_t'(1)) begin
                    ct.fill_valid = 1'b1;
                    next_state    = IDLE;
                end
            end
            FLSCAN: begin
                if (ct.scan_dirty) begin
                    next_state = FL0;
                end else begin
                    scan_step = 1'b1;
                    if (scan_last)
                        next_state = DONE;
                end
            end
            FL0, FL1: begin
                mem_req  = credit_ok;
                mem_we   = 1'b1;
                mem_addr = {ct.scan_tag, scan_idx, blkoff_t'(state == FL1), 2'b00};
                if (credit_ok && state == FL0) begin
                    next_state = FL1;
                end else if (credit_ok) begin
                    ct.clean_frame = 1'b1;
                    scan_step      = 1'b1;
                    next_state     = scan_last ? DONE : FLSCAN;
                end
            end
            DONE: next_state = DONE;  // held until reset
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            credits  <= '0;
            rf_word  <= '0;
            scan_idx <= '0;
            scan_way <= '0;
        end else begin
            state   <= next_state;
            credits <= credits + credit_t'(mem_credit) - credit_t'(mem_req);
            if (state == IDLE)
                rf_word <= '0;
            else if (mem_rvalid)
                rf_word <= rf_word + 1'b1;  // responses come back in order
            if (scan_step)
                {scan_idx, scan_way} <= {scan_idx, scan_way} + 1'b1;  // set-major
        end
    end

    assign flushed     = (state == DONE);
    assign ct.state    = state;
    assign ct.rf_word  = rf_word;
    assign ct.scan_idx = scan_idx;
    assign ct.scan_way = scan_way;

endmodule

// File: dcache_decode.sv
/* tag, valid, dirty and LRU store; lru[set] names the way to evict next.
   hit is only raised while a load or store is requested */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_decode (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                dmemren,
    input  logic                dmemwen,
    input  dcache_pkg::word_t   dmemaddr,
    dcache_lookup_if.lookup     lk
);
    import dcache_pkg::*;

    tag_t tag_q   [`DCACHE_SETS][`DCACHE_WAYS];
    logic valid_q [`DCACHE_SETS][`DCACHE_WAYS];
    logic dirty_q [`DCACHE_SETS][`DCACHE_WAYS];
    way_t lru_q   [`DCACHE_SETS];

    tag_t req_tag;
    idx_t req_idx;
    logic [`DCACHE_WAYS-1:0] match;

    assign req_tag = dmemaddr[31:6];
    assign req_idx = dmemaddr[5:3];

    // both ways compared in parallel
    always_comb begin
        lk.hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            match[w] = valid_q[req_idx][w] && (tag_q[req_idx][w] == req_tag);
            if (match[w])
                lk.hit_way = way_t'(w);
        end
    end

    assign lk.hit          = (dmemren | dmemwen) & (|match);
    assign lk.victim_way   = lru_q[req_idx];
    assign lk.victim_valid = valid_q[req_idx][lru_q[req_idx]];
    assign lk.victim_dirty = dirty_q[req_idx][lru_q[req_idx]];
    assign lk.victim_tag   = tag_q[req_idx][lru_q[req_idx]];
    assign lk.scan_dirty   = valid_q[lk.scan_idx][lk.scan_way] & dirty_q[lk.scan_idx][lk.scan_way];
    assign lk.scan_tag     = tag_q[lk.scan_idx][lk.scan_way];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '{default: '0};
        end else begin
            if (lk.fill_valid) begin
                valid_q[req_idx][lru_q[req_idx]] <= 1'b1;
                dirty_q[req_idx][lru_q[req_idx]] <= 1'b0;
            end else if (lk.clean_frame) begin
                dirty_q[lk.scan_idx][lk.scan_way] <= 1'b0;
            end else if (lk.set_dirty) begin
                dirty_q[req_idx][lk.hit_way] <= 1'b1;
            end
            if (lk.touch_lru)
                lru_q[req_idx] <= ~lk.hit_way;  // other way becomes LRU
        end
    end

    always_ff @(posedge CLK) begin
        if (lk.fill_valid)
            tag_q[req_idx][lru_q[req_idx]] <= req_tag;
    end

endmodule

// File: dcache_lookup_if.sv
/* lookup results from decode and array update commands from execute;
   result only observes */
`timescale 1ns/1ps

interface dcache_lookup_if (input logic CLK);
    import dcache_pkg::*;

    // lookup side, driven by decode
    logic          hit;
    way_t          hit_way;
    way_t          victim_way;
    logic          victim_dirty;
    logic          victim_valid;
    tag_t          victim_tag;
    logic          scan_dirty;   // frame under flush scan
    tag_t          scan_tag;

    // control side, driven by execute
    logic          fill_valid;   // victim frame becomes valid, clean, new tag
    logic          set_dirty;
    logic          clean_frame;  // scan frame written back
    idx_t          scan_idx;
    way_t          scan_way;
    logic          touch_lru;
    blkoff_t       rf_word;      // refill word the next response lands in
    dcache_state_e state;

    modport lookup (
        input  fill_valid, set_dirty, clean_frame, scan_idx, scan_way, touch_lru,
        output hit, hit_way, victim_way, victim_dirty, victim_valid, victim_tag,
        output scan_dirty, scan_tag
    );

    modport ctrl (
        input  hit, victim_dirty, victim_valid, victim_tag, scan_dirty, scan_tag,
        output fill_valid, set_dirty, clean_frame, scan_idx, scan_way, touch_lru,
        output rf_word, state
    );

    modport data (
        input hit, hit_way, victim_way, scan_idx, scan_way, rf_word, state
    );

endinterface

// File: dcache_pkg.sv
/* shared types of the data cache; widths follow dcache_settings.svh */
`include "dcache_settings.svh"

package dcache_pkg;

    // data word or byte address
    typedef logic [31:0] word_t;

    // address fields: tag | index | block offset | byte offset
    typedef logic [$clog2(`DCACHE_SETS)-1:0]            idx_t;
    typedef logic [$clog2(`DCACHE_WORDS_PER_BLOCK)-1:0] blkoff_t;
    typedef logic [31-2-$bits(idx_t)-$bits(blkoff_t):0] tag_t;

    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    // credits currently held toward memory
    typedef logic [$clog2(`DCACHE_MEM_CREDITS+1)-1:0] credit_t;

    // miss, write-back and flush controller
    typedef enum logic [3:0] {
        IDLE,
        WB0,     // victim word 0 out
        WB1,     // victim word 1 out
        RF0,     // refill read word 0
        RF1,     // refill read word 1
        RFWAIT,  // both responses pending or in flight
        FLSCAN,  // one frame checked per cycle
        FL0,
        FL1,
        DONE
    } dcache_state_e;

endpackage

// File: dcache_settings.svh
/* cache geometry and memory credit depth; the package typedefs assume
   power-of-two sizes and a 32-bit byte address */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// number of sets, index comes from dmemaddr[5:3]
`define DCACHE_SETS 8

// associativity, one LRU bit per set only covers 2 ways
`define DCACHE_WAYS 2

// words per block, block offset is dmemaddr[2]
`define DCACHE_WORDS_PER_BLOCK 2

// largest credit count memory may hand out
`define DCACHE_MEM_CREDITS 2

`endif
